// File: list.f
rtl/ifetch_pkg.sv
rtl/icache_refill.sv
rtl/icache.sv
rtl/fetch_unit.sv
rtl/ifetch_top.sv
dv/tb_ifetch.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_ifetch -f list.f -o sim_ifetch
./obj_dir/sim_ifetch | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log
then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: dv/tb_ifetch.sv
`timescale 1ns/1ps

module tb_ifetch;
    import ifetch_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int WAIT_LIMIT = 2000;
    localparam logic [31:0] SEED = 32'hd918;
    localparam logic [DATA_W-1:0] DATA_SALT = 32'h5a3c_0f11;
    localparam int LINE_BYTES = LINE_WORDS * 4;
    localparam logic [ADDR_W-1:0] REGION_BASE = 32'h0000_4000;
    // Four lines with indices 0 to 3
    localparam logic [ADDR_W-1:0] LOOP_BASE = 32'h0000_8000;
    localparam logic [ADDR_W-1:0] FLUSH_BASE = 32'h0000_c000;
    // Index 4 in both with different tags
    localparam logic [ADDR_W-1:0] CONFLICT_A = 32'h0001_0040;
    localparam logic [ADDR_W-1:0] CONFLICT_B = 32'h0002_0040;

    logic clk;
    logic rst;
    logic redirect_valid;
    logic [ADDR_W-1:0] redirect_pc;
    logic instr_valid;
    logic [ADDR_W-1:0] instr_pc;
    logic [DATA_W-1:0] instr_data;
    logic instr_ready;
    logic mem_req_valid;
    logic [ADDR_W-1:0] mem_req_addr;
    logic mem_req_ready;
    logic mem_rsp_valid;
    logic [DATA_W-1:0] mem_rsp_data;

    // Reference model and bookkeeping
    logic [ADDR_W-1:0] exp_pc;
    logic took;
    int ready_pct;
    int errors;
    int tests_run;
    int tests_failed;

    // Memory model and refill tracking
    logic mem_busy;
    int mem_delay;
    logic [ADDR_W-1:0] mem_addr;
    int fill_word;
    logic [ADDR_W-1:0] line_base;
    logic [ADDR_W-1:0] refill_lines [$];

    ifetch_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .instr_valid    (instr_valid),
        .instr_pc       (instr_pc),
        .instr_data     (instr_data),
        .instr_ready    (instr_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        return (~addr) + DATA_SALT;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    task automatic check_instr(input logic [ADDR_W-1:0] want_pc,
                               input logic [DATA_W-1:0] want_data,
                               input logic [ADDR_W-1:0] got_pc,
                               input logic [DATA_W-1:0] got_data);
        if (got_pc !== want_pc || got_data !== want_data)
            report_error($sformatf("instr pc %h data %h, expected pc %h data %h",
                                   got_pc, got_data, want_pc, want_data));
    endtask

    task automatic check_mem_req(input logic [ADDR_W-1:0] want, input logic [ADDR_W-1:0] got);
        if (got !== want)
            report_error($sformatf("refill address %h, expected %h", got, want));
    endtask

    task automatic check_low(input string what, input logic got);
        if (got !== 1'b0)
            report_error($sformatf("%s is %b, expected 0", what, got));
    endtask

    task automatic check_count(input string what, input int want, input int got);
        if (got != want)
            report_error($sformatf("%s is %0d, expected %0d", what, got, want));
    endtask

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed + 1, errors);
        $display("** FAIL **");
        $finish;
    endtask

    // One clock cycle with everything sampled and driven at the falling edge
    task automatic step(input logic redir, input logic [ADDR_W-1:0] target);
        @(negedge clk);
        mem_rsp_valid = 1'b0;
        if (mem_busy)
        begin
            if (mem_delay == 0)
            begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data = mem_word(mem_addr);
                mem_busy = 1'b0;
            end
            else
                mem_delay--;
        end
        mem_req_ready = ($urandom_range(3, 0) != 0);
        if (mem_req_valid && mem_req_ready)
        begin
            if (fill_word == 0)
            begin
                line_base = {mem_req_addr[ADDR_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
                refill_lines.push_back(line_base);
            end
            check_mem_req(line_base + ADDR_W'(4 * fill_word), mem_req_addr);
            fill_word = (fill_word + 1) % LINE_WORDS;
            mem_busy = 1'b1;
            mem_addr = mem_req_addr;
            mem_delay = $urandom_range(5, 0);
        end
        // Decoder holds off while a redirect is presented
        redirect_valid = redir;
        redirect_pc = target;
        instr_ready = redir ? 1'b0 : ($urandom_range(99, 0) < ready_pct);
        took = instr_valid && instr_ready;
        if (took)
        begin
            check_instr(exp_pc, mem_word(exp_pc), instr_pc, instr_data);
            exp_pc = exp_pc + 4;
        end
        if (redir)
            exp_pc = target;
    endtask

    task automatic redirect_to(input logic [ADDR_W-1:0] pc);
        step(1'b1, pc);
    endtask

    task automatic wait_instr();
        int n;
        n = 0;
        took = 1'b0;
        while (!took && n < WAIT_LIMIT)
        begin
            step(1'b0, '0);
            n++;
        end
        if (!took)
            abort_run("no instruction delivered within the cycle limit");
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors)
            $display("test %s: ok", name);
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic reset_then_fetch();
        int start_errors;
        start_errors = errors;
        rst = 1'b1;
        repeat (RESET_CYCLES)
        begin
            @(negedge clk);
            check_low("instr_valid during reset", instr_valid);
            check_low("mem_req_valid during reset", mem_req_valid);
        end
        rst = 1'b0;
        @(negedge clk);
        check_low("instr_valid after reset", instr_valid);
        check_low("mem_req_valid after reset", mem_req_valid);
        ready_pct = 100;
        wait_instr();
        finish_test("reset", start_errors);
    endtask

    task automatic stream_sequential();
        int start_errors;
        start_errors = errors;
        ready_pct = 70;
        repeat (300) wait_instr();
        finish_test("sequential fetch", start_errors);
    endtask

    task automatic walk_region_misses();
        int start_errors;
        int r;
        start_errors = errors;
        ready_pct = 80;
        redirect_to(REGION_BASE);
        wait_instr();
        refill_lines.delete();
        repeat (63) wait_instr();
        for (r = 0; r < 15; r++)
        begin
            if (r < refill_lines.size())
                check_mem_req(REGION_BASE + ADDR_W'(LINE_BYTES * (r + 1)), refill_lines[r]);
            else
                report_error($sformatf("refill %0d of the region never started", r + 1));
        end
        finish_test("refill order", start_errors);
    endtask

    task automatic spin_in_loop();
        int start_errors;
        int r;
        int k;
        int n;
        start_errors = errors;
        ready_pct = 80;
        // Warm all four lines without prefetching past the loop
        redirect_to(LOOP_BASE);
        while (exp_pc <= LOOP_BASE + 52)
            wait_instr();
        redirect_to(LOOP_BASE);
        wait_instr();
        refill_lines.delete();
        for (r = 0; r < 40; r++)
        begin
            redirect_to(LOOP_BASE + ADDR_W'(4 * $urandom_range(13, 0)));
            k = $urandom_range(4, 1);
            n = 0;
            while (n < k && exp_pc <= LOOP_BASE + 52)
            begin
                wait_instr();
                n++;
            end
        end
        check_count("refills while looping", 0, refill_lines.size());
        finish_test("hits after refill", start_errors);
    endtask

    task automatic alternate_conflicting_lines();
        int start_errors;
        int r;
        logic [ADDR_W-1:0] target;
        start_errors = errors;
        ready_pct = 80;
        redirect_to(CONFLICT_A);
        wait_instr();
        wait_instr();
        for (r = 0; r < 8; r++)
        begin
            target = (r % 2 == 0) ? CONFLICT_B : CONFLICT_A;
            refill_lines.delete();
            redirect_to(target);
            wait_instr();
            wait_instr();
            check_count("refills per switch", 1, refill_lines.size());
            check_count("open refill words", 0, fill_word);
            if (refill_lines.size() == 1)
                check_mem_req(target, refill_lines[0]);
        end
        finish_test("conflict eviction", start_errors);
    endtask

    task automatic scatter_redirects();
        int start_errors;
        int r;
        start_errors = errors;
        ready_pct = 80;
        for (r = 0; r < 40; r++)
        begin
            redirect_to(FLUSH_BASE + ADDR_W'(4 * $urandom_range(255, 0)));
            repeat ($urandom_range(6, 0)) step(1'b0, '0);
            if (r % 2 == 1)
                wait_instr();
        end
        redirect_to(FLUSH_BASE);
        wait_instr();
        finish_test("redirect flush", start_errors);
    endtask

    initial
    begin
        void'($urandom(SEED));
        rst = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        instr_ready = 1'b0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        exp_pc = RESET_PC;
        took = 1'b0;
        ready_pct = 100;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        mem_busy = 1'b0;
        mem_delay = 0;
        mem_addr = '0;
        fill_word = 0;
        line_base = '0;

        reset_then_fetch();
        stream_sequential();
        walk_region_misses();
        spin_in_loop();
        alternate_conflicting_lines();
        scatter_redirects();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: rtl/ifetch_top.sv
`timescale 1ns/1ps

module ifetch_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          redirect_valid,
    input  logic [ifetch_pkg::ADDR_W-1:0] redirect_pc,
    output logic                          instr_valid,
    output logic [ifetch_pkg::ADDR_W-1:0] instr_pc,
    output logic [ifetch_pkg::DATA_W-1:0] instr_data,
    input  logic                          instr_ready,
    output logic                          mem_req_valid,
    output logic [ifetch_pkg::ADDR_W-1:0] mem_req_addr,
    input  logic                          mem_req_ready,
    input  logic                          mem_rsp_valid,
    input  logic [ifetch_pkg::DATA_W-1:0] mem_rsp_data
);
    import ifetch_pkg::*;

    // Fetch unit to cache
    logic cpu_req_valid;
    logic [ADDR_W-1:0] cpu_req_addr;
    logic cpu_req_ready;
    logic cpu_rsp_valid;
    logic [DATA_W-1:0] cpu_rsp_data;

    // Cache to refill engine
    logic refill_start;
    logic [ADDR_W-1:0] refill_addr;
    logic fill_we;
    logic [INDEX_W-1:0] fill_index;
    logic [OFFSET_W-1:0] fill_offset;
    logic [DATA_W-1:0] fill_data;
    logic refill_done;

    fetch_unit i_fetch_unit (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_req_ready  (cpu_req_ready),
        .cpu_rsp_valid  (cpu_rsp_valid),
        .cpu_rsp_data   (cpu_rsp_data),
        .instr_valid    (instr_valid),
        .instr_pc       (instr_pc),
        .instr_data     (instr_data),
        .instr_ready    (instr_ready)
    );

    icache i_icache (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_ready (cpu_req_ready),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rsp_data  (cpu_rsp_data),
        .refill_start  (refill_start),
        .refill_addr   (refill_addr),
        .fill_we       (fill_we),
        .fill_index    (fill_index),
        .fill_offset   (fill_offset),
        .fill_data     (fill_data),
        .refill_done   (refill_done)
    );

    icache_refill i_icache_refill (
        .clk           (clk),
        .rst           (rst),
        .refill_start  (refill_start),
        .refill_addr   (refill_addr),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .fill_we       (fill_we),
        .fill_index    (fill_index),
        .fill_offset   (fill_offset),
        .fill_data     (fill_data),
        .refill_done   (refill_done)
    );

endmodule

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          redirect_valid,
    input  logic [ifetch_pkg::ADDR_W-1:0] redirect_pc,
    output logic                          cpu_req_valid,
    output logic [ifetch_pkg::ADDR_W-1:0] cpu_req_addr,
    input  logic                          cpu_req_ready,
    input  logic                          cpu_rsp_valid,
    input  logic [ifetch_pkg::DATA_W-1:0] cpu_rsp_data,
    output logic                          instr_valid,
    output logic [ifetch_pkg::ADDR_W-1:0] instr_pc,
    output logic [ifetch_pkg::DATA_W-1:0] instr_data,
    input  logic                          instr_ready
);
    import ifetch_pkg::*;

    logic [ADDR_W-1:0] pc_q;
    logic epoch_q;

    // PC and epoch of each request the cache has accepted
    logic [ADDR_W-1:0] out_pc [FETCH_CREDITS];
    logic out_epoch [FETCH_CREDITS];
    logic out_wr;
    logic out_rd;
    logic [1:0] out_count;

    // Instruction queue toward the decoder
    logic [ADDR_W-1:0] iq_pc [FETCH_CREDITS];
    logic [DATA_W-1:0] iq_data [FETCH_CREDITS];
    logic iq_wr;
    logic iq_rd;
    logic [1:0] iq_count;

    logic [2:0] used;
    logic req_fire;
    logic rsp_keep;
    logic instr_fire;

    assign used = {1'b0, iq_count} + {1'b0, out_count};

    // Only issue when a queue slot is free for the answer
    assign cpu_req_valid = !redirect_valid && (used < FETCH_CREDITS);
    assign cpu_req_addr = pc_q;
    assign req_fire = cpu_req_valid && cpu_req_ready;

    assign rsp_keep = cpu_rsp_valid && !redirect_valid && (out_epoch[out_rd] == epoch_q);

    assign instr_valid = (iq_count != 2'd0);
    assign instr_pc = iq_pc[iq_rd];
    assign instr_data = iq_data[iq_rd];
    assign instr_fire = instr_valid && instr_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc_q <= RESET_PC;
            epoch_q <= 1'b0;
        end
        else if (redirect_valid)
        begin
            pc_q <= redirect_pc;
            epoch_q <= !epoch_q;
        end
        else if (req_fire)
            pc_q <= pc_q + ADDR_W'(4);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_wr <= 1'b0;
            out_rd <= 1'b0;
            out_count <= '0;
        end
        else
        begin
            if (req_fire)
                out_wr <= !out_wr;
            if (cpu_rsp_valid)
                out_rd <= !out_rd;
            out_count <= out_count + {1'b0, req_fire} - {1'b0, cpu_rsp_valid};
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_fire)
        begin
            out_pc[out_wr] <= pc_q;
            out_epoch[out_wr] <= epoch_q;
        end
        // Retag in-flight entries so a second redirect cannot revive them
        if (redirect_valid)
        begin
            for (int i = 0; i < FETCH_CREDITS; i++)
                out_epoch[i] <= epoch_q;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            iq_wr <= 1'b0;
            iq_rd <= 1'b0;
            iq_count <= '0;
        end
        else if (redirect_valid)
        begin
            iq_wr <= 1'b0;
            iq_rd <= 1'b0;
            iq_count <= '0;
        end
        else
        begin
            if (rsp_keep)
                iq_wr <= !iq_wr;
            if (instr_fire)
                iq_rd <= !iq_rd;
            iq_count <= iq_count + {1'b0, rsp_keep} - {1'b0, instr_fire};
        end
    end

    always_ff @(posedge clk)
    begin
        if (rsp_keep)
        begin
            iq_pc[iq_wr] <= out_pc[out_rd];
            iq_data[iq_wr] <= cpu_rsp_data;
        end
    end

endmodule

// File: rtl/icache.sv
`timescale 1ns/1ps

module icache (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cpu_req_valid,
    input  logic [ifetch_pkg::ADDR_W-1:0]   cpu_req_addr,
    output logic                            cpu_req_ready,
    output logic                            cpu_rsp_valid,
    output logic [ifetch_pkg::DATA_W-1:0]   cpu_rsp_data,
    output logic                            refill_start,
    output logic [ifetch_pkg::ADDR_W-1:0]   refill_addr,
    input  logic                            fill_we,
    input  logic [ifetch_pkg::INDEX_W-1:0]  fill_index,
    input  logic [ifetch_pkg::OFFSET_W-1:0] fill_offset,
    input  logic [ifetch_pkg::DATA_W-1:0]   fill_data,
    input  logic                            refill_done
);
    import ifetch_pkg::*;

    icache_state_e state_q;
    icache_state_e state_d;

    logic [ADDR_W-1:0] req_addr_q;

    logic [NUM_LINES-1:0] valid_q;
    logic [TAG_W-1:0] tag_q [NUM_LINES];
    logic [DATA_W-1:0] data_q [NUM_LINES][LINE_WORDS];

    logic [TAG_W-1:0] req_tag;
    logic [INDEX_W-1:0] req_index;
    logic [OFFSET_W-1:0] req_offset;
    logic line_match;
    logic hit;
    logic req_fire;

    assign req_tag = req_addr_q[ADDR_W-1:TAG_LSB];
    assign req_index = req_addr_q[TAG_LSB-1:INDEX_LSB];
    assign req_offset = req_addr_q[INDEX_LSB-1:OFFSET_LSB];

    assign line_match = valid_q[req_index] && (tag_q[req_index] == req_tag);
    assign hit = (state_q == IC_LOOKUP) && line_match;

    // A hit frees the lookup stage for the next request in the same cycle
    assign cpu_req_ready = (state_q == IC_IDLE) || hit;
    assign req_fire = cpu_req_valid && cpu_req_ready;

    assign cpu_rsp_valid = hit || (state_q == IC_RESPOND);
    assign cpu_rsp_data = data_q[req_index][req_offset];

    assign refill_start = (state_q == IC_LOOKUP) && !line_match;
    assign refill_addr = req_addr_q;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IC_IDLE:
            begin
                if (req_fire)
                    state_d = IC_LOOKUP;
            end
            IC_LOOKUP:
            begin
                if (refill_start)
                    state_d = IC_REFILL;
                else if (!req_fire)
                    state_d = IC_IDLE;
            end
            IC_REFILL:
            begin
                if (refill_done)
                    state_d = IC_RESPOND;
            end
            IC_RESPOND: state_d = IC_IDLE;
            default: state_d = IC_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= IC_IDLE;
            valid_q <= '0;
        end
        else
        begin
            state_q <= state_d;
            // Line becomes visible only once all four words are in
            if (refill_done)
                valid_q[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_fire)
            req_addr_q <= cpu_req_addr;
        if (refill_done)
            tag_q[req_index] <= req_tag;
        if (fill_we)
            data_q[fill_index][fill_offset] <= fill_data;
    end

endmodule

// File: rtl/icache_refill.sv
`timescale 1ns/1ps

module icache_refill (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            refill_start,
    input  logic [ifetch_pkg::ADDR_W-1:0]   refill_addr,
    output logic                            mem_req_valid,
    output logic [ifetch_pkg::ADDR_W-1:0]   mem_req_addr,
    input  logic                            mem_req_ready,
    input  logic                            mem_rsp_valid,
    input  logic [ifetch_pkg::DATA_W-1:0]   mem_rsp_data,
    output logic                            fill_we,
    output logic [ifetch_pkg::INDEX_W-1:0]  fill_index,
    output logic [ifetch_pkg::OFFSET_W-1:0] fill_offset,
    output logic [ifetch_pkg::DATA_W-1:0]   fill_data,
    output logic                            refill_done
);
    import ifetch_pkg::*;

    refill_state_e state_q;

    // Tag and index of the line being filled
    logic [ADDR_W-INDEX_LSB-1:0] line_q;
    logic [OFFSET_W-1:0] word_q;
    logic last_word;

    assign mem_req_valid = (state_q == RF_REQ);
    assign mem_req_addr = {line_q, word_q, {OFFSET_LSB{1'b0}}};

    // Returned word goes straight into the data array
    assign fill_we = (state_q == RF_WAIT) && mem_rsp_valid;
    assign fill_index = line_q[INDEX_W-1:0];
    assign fill_offset = word_q;
    assign fill_data = mem_rsp_data;

    assign last_word = (word_q == OFFSET_W'(LINE_WORDS - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= RF_IDLE;
            word_q <= '0;
            refill_done <= 1'b0;
        end
        else
        begin
            refill_done <= 1'b0;
            case (state_q)
                RF_IDLE:
                begin
                    if (refill_start)
                    begin
                        line_q <= refill_addr[ADDR_W-1:INDEX_LSB];
                        word_q <= '0;
                        state_q <= RF_REQ;
                    end
                end
                RF_REQ:
                begin
                    if (mem_req_ready)
                        state_q <= RF_WAIT;
                end
                RF_WAIT:
                begin
                    if (mem_rsp_valid)
                    begin
                        word_q <= word_q + 1'b1;
                        if (last_word)
                        begin
                            refill_done <= 1'b1;
                            state_q <= RF_IDLE;
                        end
                        else
                            state_q <= RF_REQ;
                    end
                end
                default: state_q <= RF_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/ifetch_pkg.sv
package ifetch_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Cache geometry
    localparam int LINE_WORDS = 4;
    localparam int NUM_LINES = 16;

    // Address split into tag, index, offset and byte fields
    localparam int OFFSET_W = $clog2(LINE_WORDS);
    localparam int INDEX_W = $clog2(NUM_LINES);
    localparam int OFFSET_LSB = 2;
    localparam int INDEX_LSB = OFFSET_LSB + OFFSET_W;
    localparam int TAG_LSB = INDEX_LSB + INDEX_W;
    localparam int TAG_W = ADDR_W - TAG_LSB;

    localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0100;

    // Queued instructions plus outstanding requests never exceed this
    localparam int FETCH_CREDITS = 2;

    typedef enum logic [1:0] {
        IC_IDLE,
        IC_LOOKUP,
        IC_REFILL,
        IC_RESPOND
    } icache_state_e;

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_REQ,
        RF_WAIT
    } refill_state_e;

endpackage
